//--- cpu8086_pkg.sv
// 8086 fetch core definitions
package cpu8086_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------

    // Data and register width
    localparam int WORD_W    = 16;
    // Physical address, segment * 16 + offset
    localparam int ADDR_W    = 20;
    localparam int SEG_SHIFT = 4;
    // Flag register as seen on o_flags
    localparam int FLAGS_W   = 12;

    // ------------------------------------------------------------------
    // Reset values
    // ------------------------------------------------------------------

    // Code segment, fixed
    localparam logic [15:0] CS_RESET = 16'h0000;
    localparam logic [15:0] IP_RESET = 16'h0000;
    // Stack segment and pointer, SP kept even
    localparam logic [15:0] SS_RESET = 16'hAAAA;
    localparam logic [15:0] SP_RESET = 16'h0100;

    // ------------------------------------------------------------------
    // Opcodes
    // ------------------------------------------------------------------

    localparam logic [7:0] OPC_NOP        = 8'h90;
    localparam logic [7:0] OPC_JMP_REL8   = 8'hEB;
    localparam logic [7:0] OPC_JMP_REL16  = 8'hE9;
    localparam logic [7:0] OPC_CALL_REL16 = 8'hE8;

    // Flag ops, bit 0 of the opcode is the new flag value
    localparam logic [7:0] OPC_CLC = 8'hF8;
    localparam logic [7:0] OPC_STC = 8'hF9;
    localparam logic [7:0] OPC_CLI = 8'hFA;
    localparam logic [7:0] OPC_STI = 8'hFB;
    localparam logic [7:0] OPC_CLD = 8'hFC;
    localparam logic [7:0] OPC_STD = 8'hFD;

    // Prefixes, skipped one byte per cycle
    localparam logic [7:0] OPC_SEG_ES = 8'h26;
    localparam logic [7:0] OPC_SEG_CS = 8'h2E;
    localparam logic [7:0] OPC_SEG_SS = 8'h36;
    localparam logic [7:0] OPC_SEG_DS = 8'h3E;
    localparam logic [7:0] OPC_REPNZ  = 8'hF2;
    localparam logic [7:0] OPC_REPZ   = 8'hF3;

    // Flag bit positions
    localparam int FLAG_CF = 0;
    localparam int FLAG_IF = 9;
    localparam int FLAG_DF = 10;

    // Sequencer states
    typedef enum logic [1:0] {
        ST_FETCH = 2'd0,
        ST_IMM   = 2'd1,
        ST_PUSH  = 2'd2,
        ST_HALT  = 2'd3
    } seq_state_t;

endpackage

//--- cpu8086_bus_port.sv
// Physical address and byte lane
`timescale 1ns/10ps

module cpu8086_bus_port (
    // Code pointer from sequencer
    input  logic [cpu8086_pkg::WORD_W-1:0] i_ip,
    // Stack access request from push unit
    input  logic                           i_stack_sel,
    input  logic [cpu8086_pkg::WORD_W-1:0] i_stack_ea,
    // Memory read word
    input  logic [cpu8086_pkg::WORD_W-1:0] i_data,
    output logic [cpu8086_pkg::ADDR_W-1:0] o_addr,
    output logic [7:0]                     o_byte
);

    logic [cpu8086_pkg::WORD_W-1:0] segment;
    logic [cpu8086_pkg::WORD_W-1:0] offset;
    logic [cpu8086_pkg::ADDR_W-1:0] seg_base;
    logic [cpu8086_pkg::ADDR_W-1:0] offset_ext;
    logic [cpu8086_pkg::ADDR_W-1:0] phys_addr;

    // SS:SP during a push, CS:IP otherwise
    assign segment = i_stack_sel ? cpu8086_pkg::SS_RESET : cpu8086_pkg::CS_RESET;
    assign offset  = i_stack_sel ? i_stack_ea : i_ip;

    // Segment * 16
    assign seg_base   = {segment, {cpu8086_pkg::SEG_SHIFT{1'b0}}};
    assign offset_ext = {{(cpu8086_pkg::ADDR_W - cpu8086_pkg::WORD_W){1'b0}}, offset};

    // Wraps at 1 MB
    assign phys_addr = seg_base + offset_ext;
    assign o_addr    = phys_addr;

    // Odd address reads the high lane
    assign o_byte = phys_addr[0] ? i_data[15:8] : i_data[7:0];

endmodule

//--- cpu8086_imm_gather.sv
// Immediate and displacement gatherer
`timescale 1ns/10ps

module cpu8086_imm_gather (
    input  logic                           clock,
    input  logic                           i_arst_n,
    input  logic                           i_locked,
    // High while the opcode word is on the bus
    input  logic                           i_capture,
    input  logic                           i_ip_odd,
    input  logic [cpu8086_pkg::WORD_W-1:0] i_data,
    output logic [cpu8086_pkg::WORD_W-1:0] o_rel8,
    output logic [cpu8086_pkg::WORD_W-1:0] o_imm16
);

    // Opcode sat at an odd address
    logic       opc_odd_q;
    // Byte after an aligned opcode
    logic [7:0] opc_hi_q;
    logic       odd_sel;
    logic [7:0] rel8_byte;

    always_ff @(posedge clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            opc_odd_q <= 1'b0;
        end else if (i_locked && i_capture) begin
            opc_odd_q <= i_ip_odd;
        end
    end

    always_ff @(posedge clock) begin
        if (i_locked && i_capture) begin
            opc_hi_q <= i_data[15:8];
        end
    end

    // Opcode cycle uses the live IP bit, later cycles the latched one
    assign odd_sel   = i_capture ? i_ip_odd : opc_odd_q;
    // Aligned: high byte of opcode word, else low byte of next word
    assign rel8_byte = odd_sel ? i_data[7:0] : i_data[15:8];
    assign o_rel8    = {{(cpu8086_pkg::WORD_W - 8){rel8_byte[7]}}, rel8_byte};

    // Odd opcode leaves both immediate bytes in one aligned word
    assign o_imm16 = opc_odd_q ? i_data : {i_data[7:0], opc_hi_q};

endmodule

//--- cpu8086_stack_push.sv
// Stack pointer and push write
`timescale 1ns/10ps

module cpu8086_stack_push (
    input  logic                           clock,
    input  logic                           i_arst_n,
    input  logic                           i_locked,
    // Push request and value from sequencer
    input  logic                           i_start,
    input  logic [cpu8086_pkg::WORD_W-1:0] i_value,
    // Address override towards bus port
    output logic                           o_stack_sel,
    output logic [cpu8086_pkg::WORD_W-1:0] o_stack_ea,
    // Memory write side
    output logic [cpu8086_pkg::WORD_W-1:0] o_data,
    output logic                           o_wr,
    output logic                           o_done
);

    // ------------------------------------------------------------------
    // Stack pointer
    // ------------------------------------------------------------------

    logic [cpu8086_pkg::WORD_W-1:0] sp_q;
    logic [cpu8086_pkg::WORD_W-1:0] sp_dec;
    // One-cycle write phase
    logic                           push_q;

    // Pre-decrement, word push
    assign sp_dec = sp_q - 2'd2;

    always_ff @(posedge clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            sp_q   <= cpu8086_pkg::SP_RESET;
            push_q <= 1'b0;
        end else if (i_locked) begin
            // Start is a single pulse, so this drops after one cycle
            push_q <= i_start;
            if (i_start) begin
                sp_q <= sp_dec;
            end
        end
    end

    // ------------------------------------------------------------------
    // Write data
    // ------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (i_locked && i_start) begin
            o_data <= i_value;
        end
    end

    // New SP is also the write address
    assign o_stack_ea = sp_q;

    // Stack address, strobe and completion share the phase
    assign o_stack_sel = push_q;
    assign o_wr        = push_q;
    assign o_done      = push_q;

endmodule

//--- cpu8086_sequencer.sv
// Instruction sequencer
`timescale 1ns/10ps

module cpu8086_sequencer (
    input  logic                            clock,
    input  logic                            i_arst_n,
    input  logic                            i_locked,
    // Code byte at CS:IP
    input  logic [7:0]                      i_byte,
    // Gathered displacements
    input  logic [cpu8086_pkg::WORD_W-1:0]  i_rel8,
    input  logic [cpu8086_pkg::WORD_W-1:0]  i_imm16,
    input  logic                            i_push_done,
    output logic [cpu8086_pkg::WORD_W-1:0]  o_ip,
    output logic                            o_capture,
    output logic                            o_push_start,
    output logic [cpu8086_pkg::WORD_W-1:0]  o_ret_addr,
    output logic [cpu8086_pkg::FLAGS_W-1:0] o_flags
);

    // ------------------------------------------------------------------
    // State
    // ------------------------------------------------------------------

    cpu8086_pkg::seq_state_t         state_q;
    logic [cpu8086_pkg::WORD_W-1:0]  ip_q;
    // Opcode under execution
    logic [7:0]                      opc_q;
    // Opcode address was odd
    logic                            op_odd_q;
    logic [cpu8086_pkg::FLAGS_W-1:0] flags_q;

    logic [cpu8086_pkg::WORD_W-1:0]  ip_inc1;
    logic [cpu8086_pkg::WORD_W-1:0]  ip_inc2;
    logic [cpu8086_pkg::WORD_W-1:0]  instr_end;
    logic [cpu8086_pkg::WORD_W-1:0]  disp;
    logic [cpu8086_pkg::WORD_W-1:0]  target;

    // ------------------------------------------------------------------
    // Branch arithmetic
    // ------------------------------------------------------------------

    assign ip_inc1 = ip_q + 1'b1;
    assign ip_inc2 = ip_q + 2'd2;

    // In ST_IMM IP points at the immediate word.
    // Odd rel16 opcode: both bytes still ahead, end is IP+2.
    // Even rel16 or odd rel8: one byte left, end is IP+1.
    assign instr_end = (op_odd_q && (opc_q != cpu8086_pkg::OPC_JMP_REL8)) ? ip_inc2 : ip_inc1;

    assign disp   = (opc_q == cpu8086_pkg::OPC_JMP_REL8) ? i_rel8 : i_imm16;
    assign target = instr_end + disp;

    // Gatherer latches on every opcode cycle
    assign o_capture = (state_q == cpu8086_pkg::ST_FETCH);

    // Return address goes out with the push request
    assign o_push_start = (state_q == cpu8086_pkg::ST_IMM) &&
                          (opc_q == cpu8086_pkg::OPC_CALL_REL16);
    assign o_ret_addr   = instr_end;

    // ------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------

    always_ff @(posedge clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q  <= cpu8086_pkg::ST_FETCH;
            ip_q     <= cpu8086_pkg::IP_RESET;
            opc_q    <= cpu8086_pkg::OPC_NOP;
            op_odd_q <= 1'b0;
            flags_q  <= '0;
        end else if (i_locked) begin
            case (state_q)
                cpu8086_pkg::ST_FETCH: begin
                    opc_q    <= i_byte;
                    op_odd_q <= ip_q[0];
                    case (i_byte)
                        // Prefixes carry no state here
                        cpu8086_pkg::OPC_SEG_ES,
                        cpu8086_pkg::OPC_SEG_CS,
                        cpu8086_pkg::OPC_SEG_SS,
                        cpu8086_pkg::OPC_SEG_DS,
                        cpu8086_pkg::OPC_REPNZ,
                        cpu8086_pkg::OPC_REPZ,
                        cpu8086_pkg::OPC_NOP: begin
                            ip_q <= ip_inc1;
                        end
                        cpu8086_pkg::OPC_CLC,
                        cpu8086_pkg::OPC_STC: begin
                            ip_q                          <= ip_inc1;
                            flags_q[cpu8086_pkg::FLAG_CF] <= i_byte[0];
                        end
                        cpu8086_pkg::OPC_CLI,
                        cpu8086_pkg::OPC_STI: begin
                            ip_q                          <= ip_inc1;
                            flags_q[cpu8086_pkg::FLAG_IF] <= i_byte[0];
                        end
                        cpu8086_pkg::OPC_CLD,
                        cpu8086_pkg::OPC_STD: begin
                            ip_q                          <= ip_inc1;
                            flags_q[cpu8086_pkg::FLAG_DF] <= i_byte[0];
                        end
                        cpu8086_pkg::OPC_JMP_REL8: begin
                            if (!ip_q[0]) begin
                                // rel8 already in the high lane
                                ip_q <= ip_inc2 + i_rel8;
                            end else begin
                                ip_q    <= ip_inc1;
                                state_q <= cpu8086_pkg::ST_IMM;
                            end
                        end
                        cpu8086_pkg::OPC_JMP_REL16,
                        cpu8086_pkg::OPC_CALL_REL16: begin
                            // Step to the next aligned word
                            ip_q    <= ip_q[0] ? ip_inc1 : ip_inc2;
                            state_q <= cpu8086_pkg::ST_IMM;
                        end
                        default: begin
                            // Unknown opcode, IP frozen
                            state_q <= cpu8086_pkg::ST_HALT;
                        end
                    endcase
                end
                cpu8086_pkg::ST_IMM: begin
                    ip_q <= target;
                    if (opc_q == cpu8086_pkg::OPC_CALL_REL16) begin
                        state_q <= cpu8086_pkg::ST_PUSH;
                    end else begin
                        state_q <= cpu8086_pkg::ST_FETCH;
                    end
                end
                cpu8086_pkg::ST_PUSH: begin
                    // Write cycle in progress
                    if (i_push_done) begin
                        state_q <= cpu8086_pkg::ST_FETCH;
                    end
                end
                default: begin
                    state_q <= cpu8086_pkg::ST_HALT;
                end
            endcase
        end
    end

    assign o_ip    = ip_q;
    assign o_flags = flags_q;

endmodule

//--- cpu8086_core.sv
// 8086 fetch and branch core
`timescale 1ns/10ps

module cpu8086_core (
    input  logic                            clock,
    input  logic                            i_arst_n,
    // PLL lock, run enable
    input  logic                            i_locked,
    input  logic [cpu8086_pkg::WORD_W-1:0]  i_data,
    output logic [cpu8086_pkg::ADDR_W-1:0]  o_addr,
    output logic [cpu8086_pkg::WORD_W-1:0]  o_data,
    output logic                            o_wr,
    output logic [cpu8086_pkg::FLAGS_W-1:0] o_flags
);

    // ------------------------------------------------------------------
    // Internal nets
    // ------------------------------------------------------------------

    logic [cpu8086_pkg::WORD_W-1:0] ip;
    logic [7:0]                     code_byte;
    logic [cpu8086_pkg::WORD_W-1:0] rel8;
    logic [cpu8086_pkg::WORD_W-1:0] imm16;
    logic                           capture;
    logic                           push_start;
    logic [cpu8086_pkg::WORD_W-1:0] ret_addr;
    logic                           push_done;
    logic                           stack_sel;
    logic [cpu8086_pkg::WORD_W-1:0] stack_ea;

    // Control
    cpu8086_sequencer i_cpu8086_sequencer (
        .clock        (clock),
        .i_arst_n     (i_arst_n),
        .i_locked     (i_locked),
        .i_byte       (code_byte),
        .i_rel8       (rel8),
        .i_imm16      (imm16),
        .i_push_done  (push_done),
        .o_ip         (ip),
        .o_capture    (capture),
        .o_push_start (push_start),
        .o_ret_addr   (ret_addr),
        .o_flags      (o_flags)
    );

    // Address mux and lane select
    cpu8086_bus_port i_cpu8086_bus_port (
        .i_ip        (ip),
        .i_stack_sel (stack_sel),
        .i_stack_ea  (stack_ea),
        .i_data      (i_data),
        .o_addr      (o_addr),
        .o_byte      (code_byte)
    );

    cpu8086_imm_gather i_cpu8086_imm_gather (
        .clock     (clock),
        .i_arst_n  (i_arst_n),
        .i_locked  (i_locked),
        .i_capture (capture),
        .i_ip_odd  (ip[0]),
        .i_data    (i_data),
        .o_rel8    (rel8),
        .o_imm16   (imm16)
    );

    // CALL return address write
    cpu8086_stack_push i_cpu8086_stack_push (
        .clock       (clock),
        .i_arst_n    (i_arst_n),
        .i_locked    (i_locked),
        .i_start     (push_start),
        .i_value     (ret_addr),
        .o_stack_sel (stack_sel),
        .o_stack_ea  (stack_ea),
        .o_data      (o_data),
        .o_wr        (o_wr),
        .o_done      (push_done)
    );

endmodule

//--- tb_cpu8086_memory.sv
// Code and stack memory model
`timescale 1ns/10ps

module tb_cpu8086_memory (
    input  logic                           clock,
    input  logic [cpu8086_pkg::ADDR_W-1:0] i_addr,
    input  logic [cpu8086_pkg::WORD_W-1:0] i_wdata,
    input  logic                           i_wr,
    output logic [cpu8086_pkg::WORD_W-1:0] o_rdata
);

    // One word per even byte address, whole 1 MB space
    localparam int DEPTH     = 1 << (cpu8086_pkg::ADDR_W - 1);
    localparam int LOG_DEPTH = 8;

    logic [15:0] words [0:DEPTH-1];
    // Write log, in order of arrival
    logic [19:0] log_addr [0:LOG_DEPTH-1];
    logic [15:0] log_data [0:LOG_DEPTH-1];
    int          write_count = 0;

    // Zero-wait read
    assign o_rdata = words[i_addr[19:1]];

    always @(posedge clock) begin
        if (i_wr) begin
            words[i_addr[19:1]] <= i_wdata;
            if (write_count < LOG_DEPTH) begin
                log_addr[write_count] <= i_addr;
                log_data[write_count] <= i_wdata;
            end
            write_count <= write_count + 1;
        end
    end

    // Background pattern, every word address gives its own value
    task automatic fill_pattern();
        int idx;
        for (idx = 0; idx < DEPTH; idx++) begin
            words[idx] = idx[15:0] ^ {13'h0, idx[18:16]} ^ 16'h5A3C;
        end
    endtask

    // Byte store into one lane of a word
    task automatic load_byte(input logic [19:0] addr, input logic [7:0] value);
        if (addr[0]) begin
            words[addr[19:1]][15:8] = value;
        end else begin
            words[addr[19:1]][7:0] = value;
        end
    endtask

endmodule

//--- tb_cpu8086_core.sv
// Testbench for the 8086 fetch core
`timescale 1ns/10ps

module tb_cpu8086_core;

    // ------------------------------------------------------------------
    // Run length
    // ------------------------------------------------------------------

    localparam int RESET_CYCLES     = 16;
    localparam int LOCK_HOLD_CYCLES = 20;
    // Sum of the instruction cycle counts of the program
    localparam int PROGRAM_CYCLES   = 26;
    localparam int HALT_WINDOW      = 20;
    localparam int RUN_CYCLES       = RESET_CYCLES + LOCK_HOLD_CYCLES + PROGRAM_CYCLES
                                      + HALT_WINDOW;
    // About twice the run, rounded to 200
    localparam int TIMEOUT_CYCLES   = 2 * RUN_CYCLES + 36;
    localparam int FETCH_LOG_DEPTH  = 256;

    // ------------------------------------------------------------------
    // Program layout, each target is instruction end plus displacement
    // ------------------------------------------------------------------

    localparam logic [15:0] JMP8_FWD_IP     = 16'h000C;
    localparam logic [7:0]  JMP8_FWD_DISP   = 8'h0A;
    localparam logic [15:0] JMP8_FWD_END    = JMP8_FWD_IP + 16'd2;
    localparam logic [15:0] JMP8_FWD_TGT    = JMP8_FWD_END
                                              + {{8{JMP8_FWD_DISP[7]}}, JMP8_FWD_DISP};
    // NOP at the landing spot, then an odd JMP rel8 backwards
    localparam logic [15:0] JMP8_BACK_IP    = JMP8_FWD_TGT + 16'd1;
    localparam logic [7:0]  JMP8_BACK_DISP  = 8'hF5;
    localparam logic [15:0] JMP8_BACK_TGT   = JMP8_BACK_IP + 16'd2
                                              + {{8{JMP8_BACK_DISP[7]}}, JMP8_BACK_DISP};
    localparam logic [15:0] JMP16_EVEN_IP   = JMP8_BACK_TGT;
    localparam logic [15:0] JMP16_EVEN_DISP = 16'h00EE;
    localparam logic [15:0] JMP16_ODD_IP    = JMP16_EVEN_IP + 16'd3 + JMP16_EVEN_DISP;
    // Wraps past FFFF
    localparam logic [15:0] JMP16_ODD_DISP  = 16'hFF3C;
    localparam logic [15:0] CALL_EVEN_IP    = JMP16_ODD_IP + 16'd3 + JMP16_ODD_DISP;
    localparam logic [15:0] CALL_EVEN_DISP  = 16'h001E;
    localparam logic [15:0] CALL_ODD_IP     = CALL_EVEN_IP + 16'd3 + CALL_EVEN_DISP;
    localparam logic [15:0] CALL_ODD_DISP   = 16'h000C;
    localparam logic [15:0] HALT_IP         = CALL_ODD_IP + 16'd3 + CALL_ODD_DISP;
    // HLT is not decoded, so it stops the core
    localparam logic [7:0]  HALT_OPCODE     = 8'hF4;

    // First push lands at SS:SP-2
    localparam logic [19:0] FIRST_PUSH_ADDR = {cpu8086_pkg::SS_RESET, 4'h0}
                                              + cpu8086_pkg::SP_RESET - 20'd2;

    logic        clock = 1'b0;
    logic        arst_n;
    logic        locked;
    logic [15:0] bus_rdata;
    logic [15:0] bus_wdata;
    logic [19:0] bus_addr;
    logic        bus_wr;
    logic [11:0] flags;

    int          error_count  = 0;
    int          test_errors  = 0;
    int          test_count   = 0;
    int          failed_tests = 0;
    int          cycle_count  = 0;
    int          wr_count     = 0;
    int          fetch_count  = 0;
    logic [19:0] fetch_log [0:FETCH_LOG_DEPTH-1];
    string       test_name;

    cpu8086_core i_cpu8086_core (
        .clock    (clock),
        .i_arst_n (arst_n),
        .i_locked (locked),
        .i_data   (bus_rdata),
        .o_addr   (bus_addr),
        .o_data   (bus_wdata),
        .o_wr     (bus_wr),
        .o_flags  (flags)
    );

    tb_cpu8086_memory i_tb_cpu8086_memory (
        .clock   (clock),
        .i_addr  (bus_addr),
        .i_wdata (bus_wdata),
        .i_wr    (bus_wr),
        .o_rdata (bus_rdata)
    );

    always #10 clock = ~clock;

    // ------------------------------------------------------------------
    // Bus monitor and timeout
    // ------------------------------------------------------------------

    // Pre-edge values, so one entry per enabled cycle
    always @(posedge clock) begin
        if (arst_n && locked) begin
            if (bus_wr) begin
                wr_count++;
            end else if (fetch_count < FETCH_LOG_DEPTH) begin
                fetch_log[fetch_count] = bus_addr;
                fetch_count++;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------

    function automatic logic [19:0] code_addr(input logic [15:0] ip);
        return {cpu8086_pkg::CS_RESET, 4'h0} + {4'h0, ip};
    endfunction

    function automatic logic [11:0] flag_word(input logic cf, input logic ie, input logic df);
        logic [11:0] value;
        value = '0;
        value[cpu8086_pkg::FLAG_CF] = cf;
        value[cpu8086_pkg::FLAG_IF] = ie;
        value[cpu8086_pkg::FLAG_DF] = df;
        return value;
    endfunction

    task automatic note_error();
        error_count++;
        test_errors++;
    endtask

    task automatic check_value(input string sig_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERROR t=%0t %s expected %0h actual %0h", $time, sig_name,
                     expected, actual);
            note_error();
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        test_count++;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("test %0d %s: ok", test_count, test_name);
        end else begin
            failed_tests++;
            $display("test %0d %s: failed, %0d errors", test_count, test_name, test_errors);
        end
    endtask

    // Opcode must be on the bus now, then the instruction runs its cycles
    task automatic run_instr(input logic [15:0] ip, input int cycles);
        check_value("o_addr", code_addr(ip), bus_addr);
        check_value("o_wr", 0, bus_wr);
        repeat (cycles) @(negedge clock);
    endtask

    // Opcode, immediate, then the write cycle
    task automatic run_call(input logic [15:0] ip, input logic [19:0] push_addr);
        int wr_before;
        wr_before = wr_count;
        check_value("o_addr", code_addr(ip), bus_addr);
        check_value("o_wr", 0, bus_wr);
        @(negedge clock);
        check_value("o_wr", 0, bus_wr);
        @(negedge clock);
        check_value("o_wr", 1, bus_wr);
        check_value("o_addr", push_addr, bus_addr);
        check_value("o_data", ip + 16'd3, bus_wdata);
        @(negedge clock);
        assert (wr_count == wr_before + 1) else begin
            $display("CALL at %h gave %0d write cycles, not one", ip, wr_count - wr_before);
            note_error();
        end
    endtask

    task automatic check_not_fetched(input int first, input logic [19:0] lo,
                                     input logic [19:0] hi);
        int idx;
        for (idx = first; idx < fetch_count; idx++) begin
            assert (fetch_log[idx] < lo || fetch_log[idx] > hi) else begin
                $display("Skipped address %h was fetched after the jump", fetch_log[idx]);
                note_error();
            end
        end
    endtask

    task automatic load_program();
        int idx;
        i_tb_cpu8086_memory.fill_pattern();
        // ES, CS, SS, DS, REPNZ, REPZ, NOP, STC, STD, STI, CLC, NOP
        i_tb_cpu8086_memory.load_byte(20'h00000, cpu8086_pkg::OPC_SEG_ES);
        i_tb_cpu8086_memory.load_byte(20'h00001, cpu8086_pkg::OPC_SEG_CS);
        i_tb_cpu8086_memory.load_byte(20'h00002, cpu8086_pkg::OPC_SEG_SS);
        i_tb_cpu8086_memory.load_byte(20'h00003, cpu8086_pkg::OPC_SEG_DS);
        i_tb_cpu8086_memory.load_byte(20'h00004, cpu8086_pkg::OPC_REPNZ);
        i_tb_cpu8086_memory.load_byte(20'h00005, cpu8086_pkg::OPC_REPZ);
        i_tb_cpu8086_memory.load_byte(20'h00006, cpu8086_pkg::OPC_NOP);
        i_tb_cpu8086_memory.load_byte(20'h00007, cpu8086_pkg::OPC_STC);
        i_tb_cpu8086_memory.load_byte(20'h00008, cpu8086_pkg::OPC_STD);
        i_tb_cpu8086_memory.load_byte(20'h00009, cpu8086_pkg::OPC_STI);
        i_tb_cpu8086_memory.load_byte(20'h0000A, cpu8086_pkg::OPC_CLC);
        i_tb_cpu8086_memory.load_byte(20'h0000B, cpu8086_pkg::OPC_NOP);
        // Skipped bytes would halt the core if fetched
        for (idx = JMP8_FWD_END; idx < JMP8_FWD_TGT; idx++) begin
            i_tb_cpu8086_memory.load_byte(code_addr(idx), HALT_OPCODE);
        end
        i_tb_cpu8086_memory.load_byte(code_addr(JMP8_FWD_IP), cpu8086_pkg::OPC_JMP_REL8);
        i_tb_cpu8086_memory.load_byte(code_addr(JMP8_FWD_IP + 1), JMP8_FWD_DISP);
        i_tb_cpu8086_memory.load_byte(code_addr(JMP8_FWD_TGT), cpu8086_pkg::OPC_NOP);
        i_tb_cpu8086_memory.load_byte(code_addr(JMP8_BACK_IP), cpu8086_pkg::OPC_JMP_REL8);
        i_tb_cpu8086_memory.load_byte(code_addr(JMP8_BACK_IP + 1), JMP8_BACK_DISP);
        place_rel16(JMP16_EVEN_IP, cpu8086_pkg::OPC_JMP_REL16, JMP16_EVEN_DISP);
        place_rel16(JMP16_ODD_IP, cpu8086_pkg::OPC_JMP_REL16, JMP16_ODD_DISP);
        place_rel16(CALL_EVEN_IP, cpu8086_pkg::OPC_CALL_REL16, CALL_EVEN_DISP);
        place_rel16(CALL_ODD_IP, cpu8086_pkg::OPC_CALL_REL16, CALL_ODD_DISP);
        i_tb_cpu8086_memory.load_byte(code_addr(HALT_IP), HALT_OPCODE);
    endtask

    // Opcode then little-endian displacement
    task automatic place_rel16(input logic [15:0] ip, input logic [7:0] opcode,
                               input logic [15:0] disp);
        i_tb_cpu8086_memory.load_byte(code_addr(ip), opcode);
        i_tb_cpu8086_memory.load_byte(code_addr(ip + 16'd1), disp[7:0]);
        i_tb_cpu8086_memory.load_byte(code_addr(ip + 16'd2), disp[15:8]);
    endtask

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------

    initial begin
        int log_mark;
        int wr_mark;
        int step;
        arst_n = 1'b0;
        locked = 1'b0;
        load_program();

        start_test("reset and run enable");
        repeat (RESET_CYCLES) @(negedge clock);
        check_value("o_wr", 0, bus_wr);
        check_value("o_addr", 0, bus_addr);
        check_value("o_flags", 0, flags);
        arst_n = 1'b1;
        // Clock runs but the core is frozen
        repeat (LOCK_HOLD_CYCLES) begin
            @(negedge clock);
            check_value("o_addr", code_addr(cpu8086_pkg::IP_RESET), bus_addr);
            check_value("o_wr", 0, bus_wr);
        end
        locked = 1'b1;
        finish_test();

        start_test("prefixes, NOP and flags");
        for (step = 0; step < 7; step++) begin
            run_instr(step, 1);
        end
        check_value("o_flags", flag_word(0, 0, 0), flags);
        run_instr(16'h0007, 1);
        check_value("o_flags", flag_word(1, 0, 0), flags);
        run_instr(16'h0008, 1);
        check_value("o_flags", flag_word(1, 0, 1), flags);
        run_instr(16'h0009, 1);
        check_value("o_flags", flag_word(1, 1, 1), flags);
        run_instr(16'h000A, 1);
        check_value("o_flags", flag_word(0, 1, 1), flags);
        run_instr(16'h000B, 1);
        finish_test();

        start_test("JMP rel8");
        log_mark = fetch_count;
        // Aligned forward, one cycle
        run_instr(JMP8_FWD_IP, 1);
        run_instr(JMP8_FWD_TGT, 1);
        check_not_fetched(log_mark, code_addr(JMP8_FWD_END), code_addr(JMP8_FWD_TGT - 16'd1));
        // Odd address backward, two cycles
        run_instr(JMP8_BACK_IP, 2);
        check_value("o_addr", code_addr(JMP8_BACK_TGT), bus_addr);
        finish_test();

        start_test("JMP rel16");
        run_instr(JMP16_EVEN_IP, 2);
        run_instr(JMP16_ODD_IP, 2);
        check_value("o_addr", code_addr(CALL_EVEN_IP), bus_addr);
        finish_test();

        start_test("CALL rel16");
        wr_mark = wr_count;
        run_call(CALL_EVEN_IP, FIRST_PUSH_ADDR);
        // Second push two bytes lower
        run_call(CALL_ODD_IP, FIRST_PUSH_ADDR - 20'd2);
        check_value("o_addr", code_addr(HALT_IP), bus_addr);
        check_value("write count", 2, wr_count - wr_mark);
        // Memory saw both pushes, in order
        check_value("write log count", 2, i_tb_cpu8086_memory.write_count);
        check_value("write log addr 0", FIRST_PUSH_ADDR,
                    i_tb_cpu8086_memory.log_addr[0]);
        check_value("write log data 0", CALL_EVEN_IP + 16'd3,
                    i_tb_cpu8086_memory.log_data[0]);
        check_value("write log addr 1", FIRST_PUSH_ADDR - 20'd2,
                    i_tb_cpu8086_memory.log_addr[1]);
        check_value("write log data 1", CALL_ODD_IP + 16'd3,
                    i_tb_cpu8086_memory.log_data[1]);
        finish_test();

        start_test("unknown opcode");
        wr_mark = wr_count;
        repeat (HALT_WINDOW) begin
            check_value("o_addr", code_addr(HALT_IP), bus_addr);
            check_value("o_wr", 0, bus_wr);
            @(negedge clock);
        end
        check_value("write count", 0, wr_count - wr_mark);
        finish_test();

        $display("Summary: %0d tests, %0d failed, %0d errors", test_count, failed_tests,
                 error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- compile.f
cpu8086_pkg.sv
cpu8086_bus_port.sv
cpu8086_imm_gather.sv
cpu8086_stack_push.sv
cpu8086_sequencer.sv
cpu8086_core.sv
tb_cpu8086_memory.sv
tb_cpu8086_core.sv

//--- Bender.yml
package:
  name: cpu8086_core

sources:
  - files:
      - cpu8086_pkg.sv
      - cpu8086_bus_port.sv
      - cpu8086_imm_gather.sv
      - cpu8086_stack_push.sv
      - cpu8086_sequencer.sv
      - cpu8086_core.sv
  - target: test
    files:
      - tb_cpu8086_memory.sv
      - tb_cpu8086_core.sv
